/* bench/ntm_output_tb.sv */
`timescale 1ns/1ps

`include "ntm_defs.svh"

module ntm_output_tb
  import ntm_pkg::*;
;

  localparam int NUM_CASES   = 7;
  localparam int WAIT_LIMIT  = 4000;
  localparam int PROMPT_LAG  = 1;
  localparam int DELAYED_LAG = 60;

  // Case table columns are y, r, w, l and credit mode (0 prompt, 1 delayed)
  int case_y    [NUM_CASES] = '{4, 1, 3, 2, 4, 3, 4};
  int case_r    [NUM_CASES] = '{2, 1, 1, 2, 2, 2, 2};
  int case_w    [NUM_CASES] = '{4, 1, 3, 3, 4, 2, 4};
  int case_l    [NUM_CASES] = '{4, 1, 2, 1, 4, 3, 4};
  int case_slow [NUM_CASES] = '{0, 0, 0, 0, 1, 1, 0};

  logic  CLK;
  logic  RST;
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;
  size_t size_y;
  size_t size_r;
  size_t size_w;
  size_t size_l;
  logic  start;
  logic  busy;
  logic  done;
  logic  y_valid;
  size_t y_index;
  data_t y_data;
  logic  y_credit;

  // Host-side copy of memory and expected elements
  data_t shadow   [`NTM_MEM_DEPTH];
  data_t expected [`NTM_Y_MAX];

  // Owned by main process
  int case_start   = 0;
  int cur_size_y   = 0;
  int credit_delay = PROMPT_LAG;

  // Owned by the monitor
  int got_count        = 0;
  int returned_count   = 0;
  int last_valid_cycle = 0;
  int due_cycle [8];

  // Owned by the consumer
  int cycle  = 0;
  int issued = 0;

  ntm_output_top dut (
    .CLK      (CLK),
    .RST      (RST),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .size_y   (size_y),
    .size_r   (size_r),
    .size_w   (size_w),
    .size_l   (size_l),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .y_valid  (y_valid),
    .y_index  (y_index),
    .y_data   (y_data),
    .y_credit (y_credit)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      fail_run("value check failed");
    end
  endtask

  // Inputs change just after the rising edge
  task automatic next_drive();
    @(posedge CLK);
    #2;
  endtask

  // Fresh random words across the whole memory
  task automatic load_memory();
    for (int a = 0; a < `NTM_MEM_DEPTH; a++) begin
      next_drive();
      shadow[a] = data_t'($urandom);
      wr_en     = 1'b1;
      wr_addr   = addr_t'(a);
      wr_data   = shadow[a];
    end
    next_drive();
    wr_en = 1'b0;
  endtask

  // Reference element with (i, k) packed densely by run-time W inside each row
  function automatic data_t model_element(int y, int nr, int nw, int nl);
    data_t acc;
    int    ka;
    int    ra;
    acc = '0;
    for (int i = 0; i < nr; i++) begin
      for (int k = 0; k < nw; k++) begin
        ka  = `NTM_K_BASE + y * `NTM_R_MAX * `NTM_W_MAX + i * nw + k;
        ra  = `NTM_R_BASE + i * nw + k;
        acc = acc + data_t'(32'(shadow[ka]) * 32'(shadow[ra]));
      end
    end
    for (int l = 0; l < nl; l++) begin
      ka  = `NTM_U_BASE + y * `NTM_L_MAX + l;
      ra  = `NTM_H_BASE + l;
      acc = acc + data_t'(32'(shadow[ka]) * 32'(shadow[ra]));
    end
    return acc;
  endfunction

  task automatic wait_for_done();
    int n;
    n = 0;
    @(negedge CLK);
    while (done !== 1'b1) begin
      if (n >= WAIT_LIMIT) begin
        fail_run("timed out waiting for done");
      end
      n++;
      @(negedge CLK);
    end
  endtask

  // All spent credits back at the DUT
  task automatic wait_for_credits();
    int n;
    n = 0;
    @(negedge CLK);
    while (issued != got_count || y_credit !== 1'b0) begin
      if (n >= WAIT_LIMIT) begin
        fail_run("timed out waiting for credits to return");
      end
      n++;
      @(negedge CLK);
    end
  endtask

  ////////////////////
  // Credit consumer
  ////////////////////

  initial begin
    y_credit = 1'b0;
    forever begin
      @(posedge CLK);
      cycle++;
      #2;
      y_credit = 1'b0;
      // One credit per cycle and oldest first
      if (issued < got_count && due_cycle[issued % 8] <= cycle) begin
        y_credit = 1'b1;
        issued++;
      end
    end
  end

  ////////////////////
  // Stream monitor
  ////////////////////

  always @(negedge CLK) begin
    if (RST === 1'b0) begin
      if (y_valid === 1'b1) begin
        if (got_count - case_start >= cur_size_y) begin
          fail_run("y_valid pulse beyond the requested number of elements");
        end else begin
          check_value("y_index", 32'(y_index), 32'(got_count - case_start));
          check_value("y_data", 32'(y_data), 32'(expected[got_count - case_start]));
          due_cycle[got_count % 8] = cycle + credit_delay;
          got_count++;
          last_valid_cycle = cycle;
          // Credit returned this cycle is not counted yet
          if (got_count - returned_count > `NTM_CREDIT_INIT) begin
            fail_run("more y_valid pulses outstanding than credits granted");
          end
        end
      end
      if (y_credit === 1'b1) begin
        returned_count++;
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(32'h9e15c6a6));
    RST     = 1'b1;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    size_y  = '0;
    size_r  = '0;
    size_w  = '0;
    size_l  = '0;
    start   = 1'b0;

    repeat (16) @(posedge CLK);
    #2;
    RST = 1'b0;

    // Quiet after reset
    for (int n = 0; n < 10; n++) begin
      @(negedge CLK);
      check_value("y_valid", 32'(y_valid), 32'd0);
      check_value("done", 32'(done), 32'd0);
      check_value("busy", 32'(busy), 32'd0);
    end

    for (int c = 0; c < NUM_CASES; c++) begin
      load_memory();
      for (int y = 0; y < case_y[c]; y++) begin
        expected[y] = model_element(y, case_r[c], case_w[c], case_l[c]);
      end
      credit_delay = case_slow[c] ? DELAYED_LAG : PROMPT_LAG;
      case_start   = got_count;
      cur_size_y   = case_y[c];

      next_drive();
      size_y = size_t'(case_y[c]);
      size_r = size_t'(case_r[c]);
      size_w = size_t'(case_w[c]);
      size_l = size_t'(case_l[c]);
      start  = 1'b1;
      next_drive();
      start = 1'b0;
      check_value("busy", 32'(busy), 32'd1);

      wait_for_done();
      check_value("element count", 32'(got_count - case_start), 32'(case_y[c]));
      check_value("done lag", 32'(cycle - last_valid_cycle), 32'd1);
      check_value("busy", 32'(busy), 32'd0);

      wait_for_credits();
    end

    $display("All tests passed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+verilog
verilog/ntm_pkg.sv
verilog/ntm_operand_memory.sv
verilog/ntm_memory_arbiter.sv
verilog/ntm_dot_engine.sv
verilog/ntm_output_vector.sv
verilog/ntm_output_top.sv
bench/ntm_output_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the NTM output testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ntm_output_sim
LOG=sim.log

verilator --binary --timing -f filelist.f --top-module ntm_output_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "Simulation ended without a pass report"
  exit 1
fi
exit 0

/* verilog/ntm_defs.svh */
`ifndef NTM_DEFS_SVH
`define NTM_DEFS_SVH

// Datapath widths
`define NTM_DATA_WIDTH 16
`define NTM_ADDR_WIDTH 6

// Largest run-time sizes
`define NTM_Y_MAX 4
`define NTM_R_MAX 2
`define NTM_W_MAX 4
`define NTM_L_MAX 4

// Operand regions, K row is R_MAX*W_MAX long, U row is L_MAX long
`define NTM_K_BASE 0
`define NTM_R_BASE 32
`define NTM_U_BASE 40
`define NTM_H_BASE 56

// Consumer credits after reset
`define NTM_CREDIT_INIT 2

`define NTM_MEM_DEPTH 60

`endif

/* verilog/ntm_dot_engine.sv */
`timescale 1ns/1ps

module ntm_dot_engine
  import ntm_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Job control
  input  logic  start,
  input  addr_t base_a,
  input  addr_t base_b,
  input  size_t length,

  // Arbiter side
  output logic  req,
  output addr_t addr,
  input  logic  gnt,
  input  logic  rvalid,
  input  data_t rdata,

  // Completion
  output logic  done,
  output data_t result
);

  // Job parameters captured at start
  addr_t base_a_r;
  addr_t base_b_r;
  size_t len_r;

  // Issue side, next pair and a/b phase
  size_t iss_pair;
  logic  iss_b;

  // Return side, pair being assembled
  size_t rcv_pair;
  logic  rcv_b;

  // a word parked until its b word arrives
  data_t a_word;
  data_t prod;

  ////////////////////
  // Request issue
  ////////////////////

  assign addr = iss_b ? addr_t'(base_b_r + addr_t'(iss_pair))
                      : addr_t'(base_a_r + addr_t'(iss_pair));

  // Wrapped product, upper half dropped
  assign prod = data_t'(a_word * rdata);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      base_a_r <= '0;
      base_b_r <= '0;
      len_r    <= '0;
      req      <= 1'b0;
      iss_pair <= '0;
      iss_b    <= 1'b0;
    end else if (start) begin
      base_a_r <= base_a;
      base_b_r <= base_b;
      len_r    <= length;
      // Empty run never touches memory
      req      <= (length != '0);
      iss_pair <= '0;
      iss_b    <= 1'b0;
    end else if (gnt) begin
      iss_b <= ~iss_b;
      if (iss_b) begin
        iss_pair <= iss_pair + size_t'(1);
        // Last b read just went out
        if (iss_pair == len_r - size_t'(1)) begin
          req <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // Accumulate
  ////////////////////

  always_ff @(posedge CLK) begin
    if (rvalid && !rcv_b) begin
      a_word <= rdata;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rcv_pair <= '0;
      rcv_b    <= 1'b0;
      result   <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        rcv_pair <= '0;
        rcv_b    <= 1'b0;
        result   <= '0;
        done     <= (length == '0);
      end else if (rvalid) begin
        rcv_b <= ~rcv_b;
        if (rcv_b) begin
          result   <= result + prod;
          rcv_pair <= rcv_pair + size_t'(1);
          // Final product in, result stays until next start
          done     <= (rcv_pair == len_r - size_t'(1));
        end
      end
    end
  end

endmodule

/* verilog/ntm_memory_arbiter.sv */
`timescale 1ns/1ps

module ntm_memory_arbiter
  import ntm_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Requesters, a is K.r engine, b is U.h engine
  input  logic  req_a,
  input  logic  req_b,
  input  addr_t addr_a,
  input  addr_t addr_b,
  output logic  gnt_a,
  output logic  gnt_b,
  output logic  rvalid_a,
  output logic  rvalid_b,
  output data_t rdata,

  // Memory read port
  output logic  rd_en,
  output addr_t rd_addr,
  input  data_t rd_data
);

  // Set when b got the last grant
  logic last_b;

  // Which requester owns the read in flight
  logic pend_a;
  logic pend_b;

  ////////////////////
  // Grant decision
  ////////////////////

  // a wins alone or when b was served last
  assign gnt_a = req_a & (~req_b | last_b);
  assign gnt_b = req_b & ~gnt_a;

  assign rd_en   = gnt_a | gnt_b;
  assign rd_addr = gnt_a ? addr_a : addr_b;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_b <= 1'b0;
      pend_a <= 1'b0;
      pend_b <= 1'b0;
    end else begin
      // Only a real grant moves the round-robin pointer
      if (rd_en) begin
        last_b <= gnt_b;
      end
      pend_a <= gnt_a;
      pend_b <= gnt_b;
    end
  end

  ////////////////////
  // Read return
  ////////////////////

  // Shared data bus, rvalid picks the owner
  assign rvalid_a = pend_a;
  assign rvalid_b = pend_b;
  assign rdata    = rd_data;

endmodule

/* verilog/ntm_operand_memory.sv */
`timescale 1ns/1ps

`include "ntm_defs.svh"

module ntm_operand_memory
  import ntm_pkg::*;
(
  input  logic  CLK,

  // Host load side
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,

  // Arbitrated read side
  input  logic  rd_en,
  input  addr_t rd_addr,
  output data_t rd_data
);

  // Operand words, contents come from the host only
  data_t mem [`NTM_MEM_DEPTH];

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // One cycle latency, data held between reads
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* verilog/ntm_output_top.sv */
`timescale 1ns/1ps

module ntm_output_top
  import ntm_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Host load port
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,

  // Run control
  input  size_t size_y,
  input  size_t size_r,
  input  size_t size_w,
  input  size_t size_l,
  input  logic  start,
  output logic  busy,
  output logic  done,

  // Output stream
  output logic  y_valid,
  output size_t y_index,
  output data_t y_data,
  input  logic  y_credit
);

  // Memory read port
  logic  rd_en;
  addr_t rd_addr;
  data_t rd_data;
  data_t rdata;

  // K.r engine
  logic  kr_req, kr_gnt, kr_rvalid, kr_start, kr_done;
  addr_t kr_addr, kr_base_a, kr_base_b;
  size_t kr_length;
  data_t kr_result;

  // U.h engine
  logic  uh_req, uh_gnt, uh_rvalid, uh_start, uh_done;
  addr_t uh_addr, uh_base_a, uh_base_b;
  size_t uh_length;
  data_t uh_result;

  ntm_operand_memory mem (
    .CLK     (CLK),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  ntm_memory_arbiter arb (
    .CLK      (CLK),
    .RST      (RST),
    .req_a    (kr_req),
    .req_b    (uh_req),
    .addr_a   (kr_addr),
    .addr_b   (uh_addr),
    .gnt_a    (kr_gnt),
    .gnt_b    (uh_gnt),
    .rvalid_a (kr_rvalid),
    .rvalid_b (uh_rvalid),
    .rdata    (rdata),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  ntm_dot_engine kr_engine (
    .CLK    (CLK),
    .RST    (RST),
    .start  (kr_start),
    .base_a (kr_base_a),
    .base_b (kr_base_b),
    .length (kr_length),
    .req    (kr_req),
    .addr   (kr_addr),
    .gnt    (kr_gnt),
    .rvalid (kr_rvalid),
    .rdata  (rdata),
    .done   (kr_done),
    .result (kr_result)
  );

  ntm_dot_engine uh_engine (
    .CLK    (CLK),
    .RST    (RST),
    .start  (uh_start),
    .base_a (uh_base_a),
    .base_b (uh_base_b),
    .length (uh_length),
    .req    (uh_req),
    .addr   (uh_addr),
    .gnt    (uh_gnt),
    .rvalid (uh_rvalid),
    .rdata  (rdata),
    .done   (uh_done),
    .result (uh_result)
  );

  ntm_output_vector ctrl (
    .CLK       (CLK),
    .RST       (RST),
    .size_y    (size_y),
    .size_r    (size_r),
    .size_w    (size_w),
    .size_l    (size_l),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .kr_start  (kr_start),
    .uh_start  (uh_start),
    .kr_base_a (kr_base_a),
    .kr_base_b (kr_base_b),
    .uh_base_a (uh_base_a),
    .uh_base_b (uh_base_b),
    .kr_length (kr_length),
    .uh_length (uh_length),
    .kr_done   (kr_done),
    .uh_done   (uh_done),
    .kr_result (kr_result),
    .uh_result (uh_result),
    .y_valid   (y_valid),
    .y_index   (y_index),
    .y_data    (y_data),
    .y_credit  (y_credit)
  );

endmodule

/* verilog/ntm_output_vector.sv */
`timescale 1ns/1ps

`include "ntm_defs.svh"

module ntm_output_vector
  import ntm_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Run control
  input  size_t size_y,
  input  size_t size_r,
  input  size_t size_w,
  input  size_t size_l,
  input  logic  start,
  output logic  busy,
  output logic  done,

  // Engine control
  output logic  kr_start,
  output logic  uh_start,
  output addr_t kr_base_a,
  output addr_t kr_base_b,
  output addr_t uh_base_a,
  output addr_t uh_base_b,
  output size_t kr_length,
  output size_t uh_length,
  input  logic  kr_done,
  input  logic  uh_done,
  input  data_t kr_result,
  input  data_t uh_result,

  // Output stream
  output logic  y_valid,
  output size_t y_index,
  output data_t y_data,
  input  logic  y_credit
);

  ovec_state_t state;

  // Run-time sizes held for the whole run
  size_t size_y_r;

  // Engine finish flags for current y
  logic kr_seen;
  logic uh_seen;
  logic both_done;

  // Credits left at the consumer
  logic [2:0] credits;

  ////////////////////
  // Engine setup
  ////////////////////

  // Both engines launch together
  assign kr_start = (state == LAUNCH);
  assign uh_start = (state == LAUNCH);

  // Row of K and row of U for current y
  assign kr_base_a = addr_t'(`NTM_K_BASE) +
                     addr_t'(y_index) * addr_t'(`NTM_R_MAX * `NTM_W_MAX);
  assign uh_base_a = addr_t'(`NTM_U_BASE) + addr_t'(y_index) * addr_t'(`NTM_L_MAX);

  // r and h vectors are shared by all y
  assign kr_base_b = addr_t'(`NTM_R_BASE);
  assign uh_base_b = addr_t'(`NTM_H_BASE);

  assign both_done = (kr_seen | kr_done) & (uh_seen | uh_done);

  ////////////////////
  // Output element
  ////////////////////

  // Only while a credit is left
  assign y_valid = (state == SEND) && (credits != '0);
  assign y_data  = kr_result + uh_result;

  // Return and spend in one cycle cancel out
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits <= 3'(`NTM_CREDIT_INIT);
    end else if (y_credit && !y_valid) begin
      credits <= credits + 3'd1;
    end else if (!y_credit && y_valid) begin
      credits <= credits - 3'd1;
    end
  end

  ////////////////////
  // Sequencer FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      busy      <= 1'b0;
      done      <= 1'b0;
      size_y_r  <= '0;
      kr_length <= '0;
      uh_length <= '0;
      y_index   <= '0;
      kr_seen   <= 1'b0;
      uh_seen   <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            size_y_r  <= size_y;
            // K.r runs over all (i, k) of one row
            kr_length <= size_t'(size_r * size_w);
            uh_length <= size_l;
            y_index   <= '0;
            busy      <= 1'b1;
            state     <= LAUNCH;
          end
        end
        LAUNCH: begin
          kr_seen <= 1'b0;
          uh_seen <= 1'b0;
          state   <= WAIT;
        end
        WAIT: begin
          // Done pulses may come in either order
          kr_seen <= kr_seen | kr_done;
          uh_seen <= uh_seen | uh_done;
          if (both_done) begin
            state <= SEND;
          end
        end
        SEND: begin
          // Stall here with no credit, engines stay idle
          if (y_valid) begin
            if (y_index == size_y_r - size_t'(1)) begin
              done  <= 1'b1;
              busy  <= 1'b0;
              state <= IDLE;
            end else begin
              y_index <= y_index + size_t'(1);
              state   <= LAUNCH;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* verilog/ntm_pkg.sv */
`include "ntm_defs.svh"

package ntm_pkg;

  ////////////////////
  // Datapath types
  ////////////////////

  // One operand or one output element
  typedef logic [`NTM_DATA_WIDTH-1:0] data_t;

  // Word address into operand memory
  typedef logic [`NTM_ADDR_WIDTH-1:0] addr_t;

  // Run-time size, loop count or index
  typedef logic [3:0] size_t;

  ////////////////////
  // Controller FSM
  ////////////////////

  typedef enum logic [1:0] {
    IDLE,
    LAUNCH,
    WAIT,
    SEND
  } ovec_state_t;

endpackage
